//--- streamPkg.sv
package streamPkg;

    // Payload byte and its sequence tag
    typedef logic [7:0]  sample_t;
    typedef logic [3:0]  seqTag_t;

    // FIFO word, gap flag on top, then tag, then byte
    typedef logic [12:0] fifoWord_t;

    localparam int GAP_BIT = 12;
    localparam int TAG_LSB = 8;

    function automatic fifoWord_t makeWord(logic gap, seqTag_t tag, sample_t data);
        return {gap, tag, data};
    endfunction

    function automatic logic wordGap(fifoWord_t word);
        return word[GAP_BIT];
    endfunction

    function automatic seqTag_t wordTag(fifoWord_t word);
        return word[GAP_BIT-1:TAG_LSB];
    endfunction

    function automatic sample_t wordSample(fifoWord_t word);
        return word[TAG_LSB-1:0];
    endfunction

endpackage

//--- statusPkg.sv
package statusPkg;

    // Bytes lost because the FIFO was full
    typedef logic [7:0] dropCount_t;

    // Counter stops here rather than wrapping
    localparam dropCount_t DROP_MAX = '1;

endpackage

//--- sampleWriter.sv
`timescale 1ns/100ps

module sampleWriter import streamPkg::*, statusPkg::*; (
    input  logic       WCLK,
    input  logic       RRESET,
    input  logic       inStrobe,
    input  sample_t    inData,
    input  logic       full,
    output logic       wrEn,
    output fifoWord_t  wrWord,
    output dropCount_t dropCount
);

    // Tag given to the next accepted byte
    seqTag_t nextTag;

    // Set by a drop, carried by the next written byte
    logic    gapPending;

    // Accept straight from the strobe, full turns it into a drop
    assign wrEn   = inStrobe && !full;
    assign wrWord = makeWord(gapPending, nextTag, inData);

    always_ff @(posedge WCLK, posedge RRESET) begin
        if (RRESET) begin
            nextTag    <= '0;
            gapPending <= 1'b0;
        end else if (wrEn) begin
            nextTag    <= nextTag + 1'b1;
            gapPending <= 1'b0;
        end else if (inStrobe) begin
            // Byte lost, tag not advanced so the stream stays contiguous
            gapPending <= 1'b1;
        end
    end

    // Saturating drop counter
    always_ff @(posedge WCLK, posedge RRESET) begin
        if (RRESET) begin
            dropCount <= '0;
        end else if (inStrobe && full && dropCount != DROP_MAX) begin
            dropCount <= dropCount + 1'b1;
        end
    end

    // Only a write from this side can fill the FIFO
    fullFromOwnWrite: assert property (
        @(posedge WCLK) disable iff (RRESET)
        $rose(full) |-> $past(wrEn)
    ) else $error("sampleWriter: FIFO went full without a write");

endmodule

//--- asyncFifo.sv
`timescale 1ns/100ps

module asyncFifo import streamPkg::*; #(
    parameter int DEPTH = 5
) (
    input  logic      WCLK,
    input  logic      RCLK,
    input  logic      RRESET,
    input  logic      wrEn,
    input  fifoWord_t wrWord,
    output logic      full,
    input  logic      rdEn,
    output fifoWord_t rdWord,
    output logic      empty
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1);

    // Toggle bit on top of the storage index
    typedef logic [IDX_W:0] ptr_t;

    fifoWord_t mem [DEPTH];

    ptr_t wrPtr;
    ptr_t rdPtr;

    // Read pointer seen from the write side
    ptr_t rdPtrMeta;
    ptr_t rdPtrW;

    // Write pointer seen from the read side
    ptr_t wrPtrMeta;
    ptr_t wrPtrR;

    // Index wraps at DEPTH-1 and flips the toggle, so any depth works
    function automatic ptr_t nextPtr(ptr_t ptr);
        ptr_t next;
        if (ptr[IDX_W-1:0] == LAST_IDX) begin
            next = {~ptr[IDX_W], {IDX_W{1'b0}}};
        end else begin
            next = {ptr[IDX_W], ptr[IDX_W-1:0] + 1'b1};
        end
        return next;
    endfunction

    // Write side
    always_ff @(posedge WCLK) begin
        if (wrEn) begin
            mem[wrPtr[IDX_W-1:0]] <= wrWord;
        end
    end

    always_ff @(posedge WCLK, posedge RRESET) begin
        if (RRESET) begin
            wrPtr <= '0;
        end else if (wrEn) begin
            wrPtr <= nextPtr(wrPtr);
        end
    end

    always_ff @(posedge WCLK, posedge RRESET) begin
        if (RRESET) begin
            rdPtrMeta <= '0;
            rdPtrW    <= '0;
        end else begin
            rdPtrMeta <= rdPtr;
            rdPtrW    <= rdPtrMeta;
        end
    end

    // Same slot, other lap
    assign full = (wrPtr[IDX_W-1:0] == rdPtrW[IDX_W-1:0])
               && (wrPtr[IDX_W] != rdPtrW[IDX_W]);

    // Read side, head word falls through
    assign rdWord = mem[rdPtr[IDX_W-1:0]];
    assign empty  = (rdPtr == wrPtrR);

    always_ff @(posedge RCLK, posedge RRESET) begin
        if (RRESET) begin
            rdPtr <= '0;
        end else if (rdEn) begin
            rdPtr <= nextPtr(rdPtr);
        end
    end

    always_ff @(posedge RCLK, posedge RRESET) begin
        if (RRESET) begin
            wrPtrMeta <= '0;
            wrPtrR    <= '0;
        end else begin
            wrPtrMeta <= wrPtr;
            wrPtrR    <= wrPtrMeta;
        end
    end

    // Neighbours are trusted to respect the flags
    writeWhileFull: assert property (
        @(posedge WCLK) disable iff (RRESET)
        wrEn |-> !full
    ) else $error("asyncFifo: write while full");

    readWhileEmpty: assert property (
        @(posedge RCLK) disable iff (RRESET)
        rdEn |-> !empty
    ) else $error("asyncFifo: read while empty");

endmodule

//--- sampleReader.sv
`timescale 1ns/100ps

module sampleReader import streamPkg::*; (
    input  logic      RCLK,
    input  logic      RRESET,
    input  fifoWord_t rdWord,
    input  logic      empty,
    input  logic      outHold,
    output logic      rdEn,
    output logic      outStrobe,
    output sample_t   outData,
    output logic      outGap,
    output logic      seqError
);

    // Tag the next popped word should carry
    seqTag_t expTag;

    // Pop whenever a word is waiting and the sink is not holding
    assign rdEn = !empty && !outHold;

    always_ff @(posedge RCLK, posedge RRESET) begin
        if (RRESET) begin
            outStrobe <= 1'b0;
            outGap    <= 1'b0;
        end else begin
            outStrobe <= rdEn;
            // Gap only meaningful alongside the strobe
            outGap    <= rdEn && wordGap(rdWord);
        end
    end

    // Payload register
    always_ff @(posedge RCLK) begin
        if (rdEn) begin
            outData <= wordSample(rdWord);
        end
    end

    // Sequence continuity check
    always_ff @(posedge RCLK, posedge RRESET) begin
        if (RRESET) begin
            expTag   <= '0;
            seqError <= 1'b0;
        end else if (rdEn) begin
            // Resync on the received tag
            expTag <= wordTag(rdWord) + 1'b1;
            if (wordTag(rdWord) != expTag) begin
                seqError <= 1'b1;
            end
        end
    end

    // Head word must already be written when the FIFO reports data
    headWordValid: assert property (
        @(posedge RCLK) disable iff (RRESET)
        rdEn |-> !$isunknown(rdWord)
    ) else $error("sampleReader: popped word holds unknown bits");

endmodule

//--- streamBridge.sv
`timescale 1ns/100ps

module streamBridge import streamPkg::*, statusPkg::*; #(
    parameter int DEPTH = 5
) (
    input  logic       WCLK,
    input  logic       RCLK,
    input  logic       RRESET,
    input  logic       inStrobe,
    input  sample_t    inData,
    input  logic       outHold,
    output logic       outStrobe,
    output sample_t    outData,
    output logic       outGap,
    output dropCount_t dropCount,
    output logic       seqError
);

    // Producer to FIFO
    fifoWord_t wrWord;
    logic      wrEn;
    logic      full;

    // FIFO to consumer
    fifoWord_t rdWord;
    logic      rdEn;
    logic      empty;

    sampleWriter i_writer (
        .WCLK      (WCLK),
        .RRESET    (RRESET),
        .inStrobe  (inStrobe),
        .inData    (inData),
        .full      (full),
        .wrEn      (wrEn),
        .wrWord    (wrWord),
        .dropCount (dropCount)
    );

    asyncFifo #(
        .DEPTH (DEPTH)
    ) i_fifo (
        .WCLK   (WCLK),
        .RCLK   (RCLK),
        .RRESET (RRESET),
        .wrEn   (wrEn),
        .wrWord (wrWord),
        .full   (full),
        .rdEn   (rdEn),
        .rdWord (rdWord),
        .empty  (empty)
    );

    sampleReader i_reader (
        .RCLK      (RCLK),
        .RRESET    (RRESET),
        .rdWord    (rdWord),
        .empty     (empty),
        .outHold   (outHold),
        .rdEn      (rdEn),
        .outStrobe (outStrobe),
        .outData   (outData),
        .outGap    (outGap),
        .seqError  (seqError)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic WCLK,
    output logic RCLK,
    output logic RRESET
);

    localparam int W_HALF       = 10;
    localparam int R_HALF       = 17;
    localparam int R_DELAY      = 7;
    localparam int RESET_CYCLES = 4;

    // Write clock, 20 ns period
    initial begin
        WCLK = 1'b0;
        forever #(W_HALF) WCLK = ~WCLK;
    end

    // Read clock, 34 ns period, starts late so the two clocks drift
    initial begin
        RCLK = 1'b0;
        #(R_DELAY);
        forever begin
            RCLK = 1'b1;
            #(R_HALF);
            RCLK = 1'b0;
            #(R_HALF);
        end
    end

    // Released on a falling edge, clear of any rising write edge
    initial begin
        RRESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge WCLK);
        @(negedge WCLK);
        RRESET = 1'b0;
    end

endmodule

//--- tb.sv
`timescale 1ns/100ps

module tb import streamPkg::*, statusPkg::*; ();

    localparam int DEPTH    = 5;
    localparam int NUM_ROWS = 4;

    logic       WCLK;
    logic       RCLK;
    logic       RRESET;
    logic       inStrobe;
    sample_t    inData;
    logic       outHold;
    logic       outStrobe;
    sample_t    outData;
    logic       outGap;
    dropCount_t dropCount;
    logic       seqError;

    // Stimulus table, one row per test
    string rowName    [NUM_ROWS] = '{"paced", "burst", "overrun", "random"};
    int    rowCount   [NUM_ROWS] = '{20, DEPTH, DEPTH + 3, 40};
    int    rowSpacing [NUM_ROWS] = '{4, 1, 1, 4};
    bit    rowHold    [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0};
    bit    rowRandom  [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};
    int    rowDrops   [NUM_ROWS] = '{0, 0, 3, 0};

    // Reference model state
    sample_t    expData [$];
    logic       expGap [$];
    logic       gapPending;
    dropCount_t expDrops;
    sample_t    countData;
    integer     seed;
    string      curName;

    tbClock i_clock (
        .WCLK   (WCLK),
        .RCLK   (RCLK),
        .RRESET (RRESET)
    );

    streamBridge #(
        .DEPTH (DEPTH)
    ) i_dut (
        .WCLK      (WCLK),
        .RCLK      (RCLK),
        .RRESET    (RRESET),
        .inStrobe  (inStrobe),
        .inData    (inData),
        .outHold   (outHold),
        .outStrobe (outStrobe),
        .outData   (outData),
        .outGap    (outGap),
        .dropCount (dropCount),
        .seqError  (seqError)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic checkSample(input string name, input sample_t expected,
                               input sample_t actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: expected %02h, actual %02h",
                              name, expected, actual));
        end
    endtask

    task automatic checkDrops(input string name, input dropCount_t expected,
                              input dropCount_t actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: expected %0d, actual %0d",
                              name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: expected %b, actual %b",
                              name, expected, actual));
        end
    endtask

    // Time budget grows with the number of bytes in the table
    function automatic int watchdogCycles();
        int total;
        total = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 60 * rowCount[r];
        end
        return total;
    endfunction

    task automatic runRow(input int r);
        int accepted;
        int predicted;
        curName   = rowName[r];
        accepted  = 0;
        predicted = 0;
        outHold   = rowHold[r];
        for (int i = 0; i < rowCount[r]; i++) begin
            if (rowRandom[r]) begin
                inData = sample_t'($random(seed));
            end else begin
                inData    = countData;
                countData = countData + 8'd1;
            end
            inStrobe = 1'b1;
            // Nothing is read while held, so only DEPTH words fit
            if (rowHold[r] && accepted >= DEPTH) begin
                gapPending = 1'b1;
                predicted++;
            end else begin
                expData.push_back(inData);
                expGap.push_back(gapPending);
                gapPending = 1'b0;
                accepted++;
            end
            @(negedge WCLK);
            inStrobe = 1'b0;
            repeat (rowSpacing[r] - 1) @(negedge WCLK);
        end
        if (predicted != rowDrops[r]) begin
            failRun($sformatf("test %s expects %0d drops but the model predicts %0d",
                              curName, rowDrops[r], predicted));
        end
        expDrops = expDrops + dropCount_t'(rowDrops[r]);
        checkDrops({curName, " dropCount"}, expDrops, dropCount);
        outHold = 1'b0;
        // Drain everything the model still expects
        while (expData.size() != 0) begin
            @(negedge RCLK);
        end
        // Idle so both pointer synchronisers catch up
        repeat (4) @(negedge WCLK);
        checkFlag({curName, " seqError"}, 1'b0, seqError);
    endtask

    // Output monitor, samples mid-cycle where outputs are stable
    always @(negedge RCLK) begin
        if (!RRESET && outStrobe === 1'b1) begin
            if (expData.size() == 0) begin
                failRun($sformatf("test %s: output byte %02h appeared with none expected",
                                  curName, outData));
            end else begin
                checkSample({curName, " outData"}, expData[0], outData);
                checkFlag({curName, " outGap"}, expGap[0], outGap);
                void'(expData.pop_front());
                void'(expGap.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        int limit;
        limit = watchdogCycles();
        repeat (limit) @(posedge WCLK);
        failRun($sformatf("run timed out after %0d WCLK cycles", limit));
    end

    initial begin
        inStrobe   = 1'b0;
        inData     = '0;
        outHold    = 1'b0;
        gapPending = 1'b0;
        expDrops   = '0;
        countData  = '0;
        seed       = 32'hd90cafbb;
        curName    = "reset";

        @(negedge RRESET);
        checkFlag("reset outStrobe", 1'b0, outStrobe);
        checkFlag("reset outGap", 1'b0, outGap);
        checkFlag("reset seqError", 1'b0, seqError);
        checkDrops("reset dropCount", '0, dropCount);
        @(negedge WCLK);

        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end

        if (expData.size() != 0) begin
            failRun($sformatf("%0d expected bytes never came out", expData.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- tb.f
streamPkg.sv
statusPkg.sv
sampleWriter.sv
asyncFifo.sv
sampleReader.sv
streamBridge.sv
tbClock.sv
tb.sv

//--- Makefile
# Verilator build and run of the stream bridge testbench

VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
